//--- logic/sdram_cfg_pkg.sv
`default_nettype none

package sdram_cfg_pkg;

  // bus side
  typedef logic [24:0] bus_adr_t;  // bank 24:23, row 22:10, column 9:0
  typedef logic [31:0] bus_dat_t;
  typedef logic [3:0]  bus_sel_t;  // also the dqm width

  // sdram side
  typedef logic [1:0]  bank_t;
  typedef logic [12:0] mem_addr_t;

  // timing counts in controller clock cycles
  localparam int POWERUP_CYCLES   = 20000;  // 100 us at 200 MHz
  localparam int INIT_REFRESHES   = 8;
  localparam int REFRESH_SPACING  = 8;      // also covers tRC
  localparam int REFRESH_INTERVAL = 780;
  localparam int ACT_TO_RW        = 4;      // tRCD plus margin
  localparam int CAS_LATENCY      = 2;
  localparam int MRS_TO_DONE      = 4;      // tMRD before the first access

  // cas 2, sequential, read burst 4, single location write
  localparam mem_addr_t MODE_WORD = 13'h0222;

  // counter widths
  typedef logic [$clog2(POWERUP_CYCLES)-1:0]   pwr_cnt_t;
  typedef logic [$clog2(REFRESH_INTERVAL)-1:0] ref_cnt_t;
  typedef logic [$clog2(INIT_REFRESHES+1)-1:0] init_ref_cnt_t;
  typedef logic [3:0]                          wait_cnt_t;  // short waits in the controller

endpackage

`default_nettype wire

//--- logic/sdram_cmd_pkg.sv
`default_nettype none

package sdram_cmd_pkg;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_MRS       = 4'b0000,
    CMD_REFRESH   = 4'b0001,
    CMD_PRECHARGE = 4'b0010,
    CMD_ACTIVATE  = 4'b0011,
    CMD_WRITE     = 4'b0100,
    CMD_READ      = 4'b0101,
    CMD_NOP       = 4'b0111,
    CMD_DESL      = 4'b1111
  } sdram_cmd_e;

  typedef enum logic [2:0] {
    INIT_WAIT,
    INIT_PRECHARGE,
    INIT_SPACE,      // gap before each refresh and before mrs
    INIT_REFRESH,
    INIT_MODE,
    INIT_MODE_WAIT,
    INIT_DONE
  } init_state_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ACTIVATE,
    ST_RW,           // ack cycle
    ST_READ_WAIT,
    ST_PRECHARGE,
    ST_REFRESH
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- logic/sdram_init_seq.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_init_seq
  import sdram_cfg_pkg::*;
  import sdram_cmd_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_i,
  output sdram_cmd_e init_cmd_o,
  output bank_t      init_ba_o,
  output mem_addr_t  init_addr_o,
  output logic       init_done_o
);

  init_state_e   state;
  pwr_cnt_t      cnt;
  init_ref_cnt_t ref_cnt;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state   <= INIT_WAIT;
      cnt     <= pwr_cnt_t'(POWERUP_CYCLES - 1);
      ref_cnt <= '0;
    end else begin
      case (state)
        INIT_WAIT: begin
          if (cnt == '0) begin
            state <= INIT_PRECHARGE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        INIT_PRECHARGE: begin
          cnt   <= pwr_cnt_t'(REFRESH_SPACING - 2);
          state <= INIT_SPACE;
        end
        INIT_SPACE: begin
          if (cnt != '0) begin
            cnt <= cnt - 1'b1;
          end else if (ref_cnt == init_ref_cnt_t'(INIT_REFRESHES)) begin
            state <= INIT_MODE;
          end else begin
            state <= INIT_REFRESH;
          end
        end
        INIT_REFRESH: begin
          ref_cnt <= ref_cnt + 1'b1;
          cnt     <= pwr_cnt_t'(REFRESH_SPACING - 2);  // next refresh spacing cycles later
          state   <= INIT_SPACE;
        end
        INIT_MODE: begin
          cnt   <= pwr_cnt_t'(MRS_TO_DONE - 2);
          state <= INIT_MODE_WAIT;
        end
        INIT_MODE_WAIT: begin
          if (cnt == '0) begin
            state <= INIT_DONE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        INIT_DONE: state <= INIT_DONE;  // held until reset
        default: state <= INIT_WAIT;
      endcase
    end
  end

  always_comb begin
    init_cmd_o  = CMD_NOP;
    init_ba_o   = '0;  // mrs goes to bank 0
    init_addr_o = '0;
    case (state)
      INIT_PRECHARGE: begin
        init_cmd_o      = CMD_PRECHARGE;
        init_addr_o[10] = 1'b1;  // all banks
      end
      INIT_REFRESH: init_cmd_o = CMD_REFRESH;
      INIT_MODE: begin
        init_cmd_o  = CMD_MRS;
        init_addr_o = MODE_WORD;
      end
      default: init_cmd_o = CMD_NOP;
    endcase
  end

  assign init_done_o = (state == INIT_DONE);

  a_done_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    init_done_o |=> init_done_o)
    else $error("init_done dropped without reset");

endmodule

`default_nettype wire

//--- logic/sdram_refresh_timer.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_refresh_timer
  import sdram_cfg_pkg::*;
(
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic enable_i,   // init done
  input  wire logic ref_ack_i,
  output logic      ref_req_o
);

  ref_cnt_t cnt;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt       <= ref_cnt_t'(REFRESH_INTERVAL - 1);
      ref_req_o <= 1'b0;
    end else if (!enable_i) begin
      cnt       <= ref_cnt_t'(REFRESH_INTERVAL - 1);
      ref_req_o <= 1'b0;
    end else if (ref_ack_i) begin
      cnt       <= ref_cnt_t'(REFRESH_INTERVAL - 1);  // interval restarts at the refresh
      ref_req_o <= 1'b0;
    end else if (cnt == '0) begin
      ref_req_o <= 1'b1;  // sticky until served
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  // the controller must only serve a refresh that was asked for
  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    ref_ack_i |-> ref_req_o)
    else $error("refresh ack without pending request");

endmodule

`default_nettype wire

//--- logic/sdram_controller.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_controller
  import sdram_cfg_pkg::*;
  import sdram_cmd_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_i,
  // bus side
  input  wire logic       cyc_i,
  input  wire logic       stb_i,
  input  wire logic       we_i,
  input  wire bus_sel_t   sel_i,
  input  wire bus_adr_t   adr_i,
  input  wire bus_dat_t   dat_i,
  output bus_dat_t        dat_o,
  output logic            ack_o,
  // power-up sequencer
  input  wire sdram_cmd_e init_cmd_i,
  input  wire bank_t      init_ba_i,
  input  wire mem_addr_t  init_addr_i,
  input  wire logic       init_done_i,
  // refresh timer
  input  wire logic       ref_req_i,
  output logic            ref_ack_o,
  // sdram pins
  output logic            cs_n_o,
  output logic            ras_n_o,
  output logic            cas_n_o,
  output logic            we_n_o,
  output bank_t           ba_o,
  output mem_addr_t       addr_o,
  output bus_sel_t        dqm_o,
  input  wire bus_dat_t   dq_i,
  output bus_dat_t        dq_o
);

  ctrl_state_e state;
  sdram_cmd_e  cmd_q;
  wait_cnt_t   delay;
  logic        select;
  logic        issue_rw;

  assign select    = cyc_i & stb_i;
  assign issue_rw  = (state == ST_ACTIVATE) && (delay == '0);
  assign ack_o     = (state == ST_RW);
  assign dat_o     = (ack_o && !we_i) ? dq_i : '0;
  assign ref_ack_o = init_done_i && (state == ST_IDLE) && ref_req_i;  // refresh beats access

  assign {cs_n_o, ras_n_o, cas_n_o, we_n_o} = cmd_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state  <= ST_IDLE;
      cmd_q  <= CMD_NOP;
      delay  <= '0;
      ba_o   <= '0;
      addr_o <= '0;
      dqm_o  <= '1;
    end else if (!init_done_i) begin
      cmd_q  <= init_cmd_i;  // sequencer owns the pins
      ba_o   <= init_ba_i;
      addr_o <= init_addr_i;
      dqm_o  <= '1;
    end else begin
      cmd_q <= CMD_NOP;
      case (state)
        ST_IDLE: begin
          if (ref_ack_o) begin
            cmd_q <= CMD_REFRESH;
            delay <= wait_cnt_t'(REFRESH_SPACING - 1);
            state <= ST_REFRESH;
          end else if (select) begin
            cmd_q  <= CMD_ACTIVATE;
            ba_o   <= adr_i[24:23];
            addr_o <= adr_i[22:10];  // row
            dqm_o  <= ~sel_i;
            delay  <= wait_cnt_t'(ACT_TO_RW);
            state  <= ST_ACTIVATE;
          end
        end
        ST_ACTIVATE: begin
          if (issue_rw) begin
            if (we_i) begin
              cmd_q <= CMD_WRITE;
              delay <= '0;
            end else begin
              cmd_q <= CMD_READ;
              delay <= wait_cnt_t'(CAS_LATENCY - 1);
            end
            addr_o <= {3'b000, adr_i[9:0]};  // column, a10 low so no auto precharge
            dqm_o  <= ~sel_i;
            state  <= ST_READ_WAIT;
          end else begin
            delay <= delay - 1'b1;
          end
        end
        // read: cas latency, write: one recovery cycle before ack
        ST_READ_WAIT: begin
          if (delay == '0) begin
            state <= ST_RW;
          end else begin
            delay <= delay - 1'b1;
          end
        end
        ST_RW: begin
          cmd_q <= CMD_PRECHARGE;  // bank still in ba_o
          state <= ST_PRECHARGE;
        end
        ST_PRECHARGE: begin
          dqm_o <= '1;
          state <= ST_IDLE;
        end
        ST_REFRESH: begin
          if (delay == '0) begin
            state <= ST_IDLE;
          end else begin
            delay <= delay - 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_rw && we_i) begin
      dq_o <= dat_i;  // launched with the WRITE command
    end
  end

  a_ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o |=> !ack_o)
    else $error("ack held for more than one cycle");

endmodule

`default_nettype wire

//--- logic/sdram_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_subsys
  import sdram_cfg_pkg::*;
  import sdram_cmd_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_i,
  input  wire logic     cyc_i,
  input  wire logic     stb_i,
  input  wire logic     we_i,
  input  wire bus_sel_t sel_i,
  input  wire bus_adr_t adr_i,
  input  wire bus_dat_t dat_i,
  output bus_dat_t      dat_o,
  output logic          ack_o,
  output logic          mem_clk_o,
  output logic          cke_o,
  output logic          cs_n_o,
  output logic          ras_n_o,
  output logic          cas_n_o,
  output logic          we_n_o,
  output bank_t         ba_o,
  output mem_addr_t     addr_o,
  output bus_sel_t      dqm_o,
  output bus_dat_t      dq_o,
  input  wire bus_dat_t dq_i
);

  sdram_cmd_e init_cmd;
  bank_t      init_ba;
  mem_addr_t  init_addr;
  logic       init_done;
  logic       ref_req;
  logic       ref_ack;

  assign mem_clk_o = ~clk_i;  // sdram samples mid-cycle
  assign cke_o     = ~rst_i;

  sdram_init_seq u_init (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .init_cmd_o  (init_cmd),
    .init_ba_o   (init_ba),
    .init_addr_o (init_addr),
    .init_done_o (init_done)
  );

  sdram_refresh_timer u_refresh (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .enable_i  (init_done),
    .ref_ack_i (ref_ack),
    .ref_req_o (ref_req)
  );

  sdram_controller u_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cyc_i       (cyc_i),
    .stb_i       (stb_i),
    .we_i        (we_i),
    .sel_i       (sel_i),
    .adr_i       (adr_i),
    .dat_i       (dat_i),
    .dat_o       (dat_o),
    .ack_o       (ack_o),
    .init_cmd_i  (init_cmd),
    .init_ba_i   (init_ba),
    .init_addr_i (init_addr),
    .init_done_i (init_done),
    .ref_req_i   (ref_req),
    .ref_ack_o   (ref_ack),
    .cs_n_o      (cs_n_o),
    .ras_n_o     (ras_n_o),
    .cas_n_o     (cas_n_o),
    .we_n_o      (we_n_o),
    .ba_o        (ba_o),
    .addr_o      (addr_o),
    .dqm_o       (dqm_o),
    .dq_i        (dq_i),
    .dq_o        (dq_o)
  );

endmodule

`default_nettype wire

//--- testbench/sdram_model.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_model
  import sdram_cfg_pkg::*;
  import sdram_cmd_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      cs_n_i,
  input  wire logic      ras_n_i,
  input  wire logic      cas_n_i,
  input  wire logic      we_n_i,
  input  wire bank_t     ba_i,
  input  wire mem_addr_t addr_i,
  input  wire bus_sel_t  dqm_i,
  input  wire bus_dat_t  wdata_i,
  output bus_dat_t       rdata_o
);

  bus_dat_t   mem [bus_adr_t];  // sparse, keyed by bank, row, column
  mem_addr_t  open_row [4];
  sdram_cmd_e cmd;
  bus_adr_t   key;
  bus_dat_t   word;
  bus_dat_t   rd_pipe;
  int         rd_cnt;

  assign cmd = sdram_cmd_e'({cs_n_i, ras_n_i, cas_n_i, we_n_i});

  initial begin
    rdata_o = '0;
    rd_cnt  = 0;
  end

  always @(posedge clk_i) begin
    if (rd_cnt > 0) begin
      rd_cnt = rd_cnt - 1;
      if (rd_cnt == 0) begin
        rdata_o <= rd_pipe;  // valid cas latency after the read
      end
    end
    key = {ba_i, open_row[ba_i], addr_i[9:0]};
    case (cmd)
      CMD_ACTIVATE: open_row[ba_i] = addr_i;
      CMD_WRITE: begin
        word = mem.exists(key) ? mem[key] : '0;
        for (int b = 0; b < 4; b++) begin
          if (!dqm_i[b]) begin
            word[8*b +: 8] = wdata_i[8*b +: 8];
          end
        end
        mem[key] = word;
      end
      CMD_READ: begin
        rd_pipe = mem.exists(key) ? mem[key] : '0;
        rd_cnt  = CAS_LATENCY - 1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- testbench/sdram_checker.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_checker
  import sdram_cfg_pkg::*;
  import sdram_cmd_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        cyc_i,
  input  wire logic        stb_i,
  input  wire logic        we_i,
  input  wire bus_sel_t    sel_i,
  input  wire bus_adr_t    adr_i,
  input  wire bus_dat_t    dat_o_i,
  input  wire logic        ack_i,
  input  wire logic        mem_clk_i,
  input  wire logic        cke_i,
  input  wire logic        cs_n_i,
  input  wire logic        ras_n_i,
  input  wire logic        cas_n_i,
  input  wire logic        we_n_i,
  input  wire bank_t       ba_i,
  input  wire mem_addr_t   addr_i,
  input  wire bus_sel_t    dqm_i,
  input  wire bus_dat_t    exp_dat_i,
  input  wire logic [31:0] test_id_i,
  input  wire logic        done_i,
  output int               err_cnt_o
);

  // longest refresh wait is one access on top of the interval
  localparam int GAP_LIMIT = REFRESH_INTERVAL + 2 * (ACT_TO_RW + CAS_LATENCY + 6);

  sdram_cmd_e cmd;
  logic       mrs_seen;
  logic       pre_all_seen;
  logic       row_open;
  logic       ack_q;
  logic       done_q;
  int         init_refs;
  int         gap;
  int         test_errs;

  assign cmd = sdram_cmd_e'({cs_n_i, ras_n_i, cas_n_i, we_n_i});

  task automatic fail(input string what);
    $display("error at %0t: %s", $time, what);
    err_cnt_o = err_cnt_o + 1;
    test_errs = test_errs + 1;
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
      err_cnt_o = err_cnt_o + 1;
      test_errs = test_errs + 1;
    end
  endtask

  initial err_cnt_o = 0;

  // memory clock and clock enable, looked at between the edges
  always @(clk_i) begin
    #1;
    if (mem_clk_i !== ~clk_i) fail("mem_clk_o is not the inverted clock");
    if (cke_i !== ~rst_i) fail("cke_o does not follow reset");
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      mrs_seen     = 1'b0;
      pre_all_seen = 1'b0;
      row_open     = 1'b0;
      ack_q        = 1'b0;
      done_q       = 1'b0;
      init_refs    = 0;
      gap          = 0;
      test_errs    = 0;
    end else begin
      if (ack_i && ack_q) fail("ack held high for two cycles");
      if (ack_i && !(cyc_i && stb_i)) fail("ack without a selected access");
      if (ack_i && !we_i) begin
        compare("dat_o", exp_dat_i, dat_o_i);
      end else begin
        compare("dat_o", '0, dat_o_i);  // idle data must be zero
      end
      if (ack_i) begin
        $display("test %0d %s adr %h: %s", test_id_i, we_i ? "write" : "read ", adr_i,
                 (test_errs == 0) ? "ok" : "failed");
        test_errs = 0;
      end
      case (cmd)
        CMD_PRECHARGE: begin
          if (!mrs_seen && addr_i[10]) pre_all_seen = 1'b1;
          row_open = 1'b0;
        end
        CMD_REFRESH: begin
          if (row_open) fail("refresh while a row is open");
          if (!mrs_seen) begin
            if (!pre_all_seen) fail("init refresh before precharge-all");
            init_refs = init_refs + 1;
          end else begin
            if (gap > GAP_LIMIT) fail("refresh came too late");
            gap = 0;
          end
        end
        CMD_MRS: begin
          if (init_refs != INIT_REFRESHES) fail("wrong number of init refreshes");
          compare("addr_o", 32'(MODE_WORD), 32'(addr_i));
          compare("ba_o", 32'd0, 32'(ba_i));
          mrs_seen = 1'b1;
          gap      = 0;
        end
        CMD_ACTIVATE: begin
          if (!mrs_seen) fail("activate before mode register write");
          if (row_open) fail("activate while a row is open");
          compare("ba_o", 32'(adr_i[24:23]), 32'(ba_i));
          compare("addr_o", 32'(adr_i[22:10]), 32'(addr_i));
          row_open = 1'b1;
        end
        CMD_READ, CMD_WRITE: begin
          if (!row_open) fail("column access with no open row");
          compare("ba_o", 32'(adr_i[24:23]), 32'(ba_i));
          compare("addr_o", 32'(adr_i[9:0]), 32'(addr_i[10:0]));  // a10 low
          if (cmd == CMD_WRITE) compare("dqm_o", 32'(bus_sel_t'(~sel_i)), 32'(dqm_i));
        end
        default: ;
      endcase
      if (mrs_seen) gap = gap + 1;
      if (done_i && !done_q) begin
        if (!mrs_seen) fail("init sequence never finished");
        if (gap > GAP_LIMIT) fail("no refresh within the interval at the end");
        if (row_open) fail("row left open at the end");
      end
      ack_q  = ack_i;
      done_q = done_i;
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_sdram_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sdram_subsys
  import sdram_cfg_pkg::*;
;

  localparam int NUM_ROWS  = 15;
  localparam int GAP_ROW   = 12;    // long idle before this row lets refreshes run
  localparam int IDLE_GAP  = 1700;
  localparam int PERIOD_NS = 20;
  localparam int WATCHDOG_NS = (POWERUP_CYCLES + IDLE_GAP + 200
                                + NUM_ROWS * (REFRESH_SPACING + ACT_TO_RW + 10)) * PERIOD_NS;

  logic      clk_i;
  logic      rst_i;
  logic      cyc_i;
  logic      stb_i;
  logic      we_i;
  bus_sel_t  sel_i;
  bus_adr_t  adr_i;
  bus_dat_t  dat_i;
  bus_dat_t  dat_o;
  logic      ack_o;
  logic      mem_clk_o;
  logic      cke_o;
  logic      cs_n_o;
  logic      ras_n_o;
  logic      cas_n_o;
  logic      we_n_o;
  bank_t     ba_o;
  mem_addr_t addr_o;
  bus_sel_t  dqm_o;
  bus_dat_t  dq_o;
  bus_dat_t  dq_i;
  bus_dat_t  exp_dat;
  int        test_id;
  logic      done;
  int        err_cnt;

  // stimulus table
  logic      t_we  [NUM_ROWS];
  bus_sel_t  t_sel [NUM_ROWS];
  bus_adr_t  t_adr [NUM_ROWS];
  bus_dat_t  t_dat [NUM_ROWS];
  bus_dat_t  t_exp [NUM_ROWS];
  bus_dat_t  shadow [bus_adr_t];  // expected memory contents
  int        n_rows;
  integer    seed;

  sdram_subsys sdram_subsys_i (
    .clk_i, .rst_i, .cyc_i, .stb_i, .we_i, .sel_i, .adr_i, .dat_i, .dat_o, .ack_o,
    .mem_clk_o, .cke_o, .cs_n_o, .ras_n_o, .cas_n_o, .we_n_o, .ba_o, .addr_o,
    .dqm_o, .dq_o, .dq_i
  );

  sdram_model u_model (
    .clk_i, .cs_n_i(cs_n_o), .ras_n_i(ras_n_o), .cas_n_i(cas_n_o), .we_n_i(we_n_o),
    .ba_i(ba_o), .addr_i(addr_o), .dqm_i(dqm_o), .wdata_i(dq_o), .rdata_o(dq_i)
  );

  sdram_checker u_check (
    .clk_i, .rst_i, .cyc_i, .stb_i, .we_i, .sel_i, .adr_i, .dat_o_i(dat_o), .ack_i(ack_o),
    .mem_clk_i(mem_clk_o), .cke_i(cke_o),
    .cs_n_i(cs_n_o), .ras_n_i(ras_n_o), .cas_n_i(cas_n_o), .we_n_i(we_n_o),
    .ba_i(ba_o), .addr_i(addr_o), .dqm_i(dqm_o), .exp_dat_i(exp_dat),
    .test_id_i(test_id), .done_i(done), .err_cnt_o(err_cnt)
  );

  always #(PERIOD_NS / 2) clk_i = ~clk_i;

  function automatic bus_adr_t make_adr(input bank_t bank, input int row, input int col);
    return {bank, 13'(row), 10'(col)};
  endfunction

  // expected read data follows the byte-merge rule
  task automatic add_row(input logic we, input bus_sel_t sel, input bus_adr_t adr,
                         input bus_dat_t dat);
    bus_dat_t word;
    word = shadow.exists(adr) ? shadow[adr] : '0;
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) word[8*b +: 8] = dat[8*b +: 8];
      end
      shadow[adr] = word;
    end
    t_we[n_rows]  = we;
    t_sel[n_rows] = sel;
    t_adr[n_rows] = adr;
    t_dat[n_rows] = dat;
    t_exp[n_rows] = we ? '0 : word;
    n_rows = n_rows + 1;
  endtask

  task automatic build_table();
    n_rows = 0;
    seed   = 37;
    add_row(1'b1, 4'hf, make_adr(2'd0, 1, 5), 32'h1122_3344);
    add_row(1'b0, 4'hf, make_adr(2'd0, 1, 5), '0);
    add_row(1'b1, 4'h5, make_adr(2'd0, 1, 5), 32'haabb_ccdd);  // partial write
    add_row(1'b0, 4'hf, make_adr(2'd0, 1, 5), '0);
    for (int b = 0; b < 4; b++) begin
      add_row(1'b1, 4'hf, make_adr(bank_t'(b), 16 * b + 2, 5), $random(seed));
    end
    for (int b = 0; b < 4; b++) begin
      add_row(1'b0, 4'hf, make_adr(bank_t'(b), 16 * b + 2, 5), '0);
    end
    add_row(1'b1, 4'h8, make_adr(2'd2, 13'h1abc, 10'h3ff), $random(seed));
    add_row(1'b0, 4'hf, make_adr(2'd2, 13'h1abc, 10'h3ff), '0);
    add_row(1'b0, 4'hf, make_adr(2'd3, 50, 5), '0);  // kept across refreshes
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    clk_i   = 1'b0;
    rst_i   = 1'b1;
    cyc_i   = 1'b0;
    stb_i   = 1'b0;
    we_i    = 1'b0;
    sel_i   = '0;
    adr_i   = '0;
    dat_i   = '0;
    exp_dat = '0;
    test_id = 0;
    done    = 1'b0;
    build_table();
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      if (i == GAP_ROW) begin
        cyc_i <= 1'b0;
        stb_i <= 1'b0;
        repeat (IDLE_GAP) @(posedge clk_i);
      end
      cyc_i   <= 1'b1;
      stb_i   <= 1'b1;
      we_i    <= t_we[i];
      sel_i   <= t_sel[i];
      adr_i   <= t_adr[i];
      dat_i   <= t_dat[i];
      exp_dat <= t_exp[i];
      test_id <= i;
      do @(posedge clk_i); while (!ack_o);
    end
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    done  <= 1'b1;
    repeat (4) @(posedge clk_i);
    $display("tests run %0d, errors %0d", n_rows, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sdram_subsys.f
logic/sdram_cfg_pkg.sv
logic/sdram_cmd_pkg.sv
logic/sdram_init_seq.sv
logic/sdram_refresh_timer.sv
logic/sdram_controller.sv
logic/sdram_subsys.sv
testbench/sdram_model.sv
testbench/sdram_checker.sv
testbench/tb_sdram_subsys.sv

//--- Makefile
# Verilator flow for the SDRAM subsystem
# override on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_sdram_subsys
FILELIST  ?= sdram_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TEST PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
